//--- verilog/dcache_pkg.sv
/*
 * Data cache shared definitions
 * Word, line and address widths and the matching types used by every
 * block of the direct-mapped write-through data cache.
 */
package dcache_pkg;

        // Data word and physical address
        localparam int WORD_W     = 64;
        localparam int ADDR_W     = 32;

        // Line geometry
        localparam int LINE_WORDS = 4;
        localparam int WORD_OFF_W = 3;
        localparam int LINE_OFF_W = 2;

        typedef logic [WORD_W-1:0] word_t;

        // Word 0 sits in the low bits
        typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

        typedef logic [ADDR_W-1:0] paddr_t;

endpackage

//--- verilog/dcache_port_arbiter.sv
/*
 * Data cache port arbiter
 * Merges the core read and write ports into a single request toward
 * the controller, read port first, and returns each done pulse to the
 * port that issued the request.
 */
`timescale 1ns/1ps

module dcache_port_arbiter (
        input  logic               clk,
        input  logic               rst,
        input  logic               rd_valid,
        input  dcache_pkg::paddr_t rd_addr,
        input  logic               wr_valid,
        input  dcache_pkg::paddr_t wr_addr,
        input  dcache_pkg::word_t  wr_data,
        input  logic               idle,
        input  logic               resp_done,
        input  dcache_pkg::word_t  resp_rdata,
        output logic               rd_ready,
        output logic               rd_done,
        output dcache_pkg::word_t  rd_data,
        output logic               wr_ready,
        output logic               wr_done,
        output logic               req_valid,
        output logic               req_write,
        output dcache_pkg::paddr_t req_addr,
        output dcache_pkg::word_t  req_wdata
);

        logic accept;
        logic owner_wr;
        logic pending;

        // Read port wins whenever it is valid
        assign rd_ready  = idle;
        assign wr_ready  = idle && !rd_valid;
        assign req_valid = rd_valid || wr_valid;
        assign req_write = !rd_valid;
        assign req_addr  = rd_valid ? rd_addr : wr_addr;
        assign req_wdata = wr_data;
        assign accept    = idle && req_valid;

        always_ff @(posedge clk) begin
                if (rst) begin
                        owner_wr <= 1'b0;
                        pending  <= 1'b0;
                end else if (accept) begin
                        owner_wr <= req_write;
                        pending  <= 1'b1;
                end else if (resp_done) begin
                        pending  <= 1'b0;
                end
        end

        // Steer the response to the owning port
        assign rd_done = resp_done && !owner_wr;
        assign wr_done = resp_done && owner_wr;
        assign rd_data = resp_rdata;

        a_done_has_owner: assert property (@(posedge clk) disable iff (rst)
                resp_done |-> pending);

endmodule

//--- verilog/dcache_array.sv
/*
 * Data cache storage
 * Direct-mapped tag, valid and line storage. A lookup registers the
 * address and returns hit and the addressed word one cycle later;
 * fills, word updates and invalidate act on the registered address.
 */
`timescale 1ns/1ps

module dcache_array #(
        parameter int INDEX_W = 4
) (
        input  logic               clk,
        input  logic               rst,
        input  logic               lookup_en,
        input  dcache_pkg::paddr_t lookup_addr,
        input  logic               fill_en,
        input  dcache_pkg::line_t  fill_line,
        input  logic               upd_en,
        input  dcache_pkg::word_t  upd_word,
        input  logic               inv_all,
        output logic               hit,
        output dcache_pkg::word_t  hit_word
);

        localparam int DEPTH  = 1 << INDEX_W;
        localparam int IDX_LO = dcache_pkg::LINE_OFF_W + dcache_pkg::WORD_OFF_W;
        localparam int TAG_W  = dcache_pkg::ADDR_W - INDEX_W - IDX_LO;

        logic [TAG_W-1:0]                  tag_mem [DEPTH];
        dcache_pkg::line_t                 data_mem [DEPTH];
        logic [DEPTH-1:0]                  valid;
        dcache_pkg::paddr_t                addr_q;
        logic [INDEX_W-1:0]                in_idx, cur_idx;
        logic [TAG_W-1:0]                  in_tag, cur_tag;
        logic [dcache_pkg::LINE_OFF_W-1:0] in_woff, cur_woff;

        assign in_idx   = lookup_addr[IDX_LO +: INDEX_W];
        assign in_tag   = lookup_addr[dcache_pkg::ADDR_W-1 -: TAG_W];
        assign in_woff  = lookup_addr[dcache_pkg::WORD_OFF_W +: dcache_pkg::LINE_OFF_W];
        assign cur_idx  = addr_q[IDX_LO +: INDEX_W];
        assign cur_tag  = addr_q[dcache_pkg::ADDR_W-1 -: TAG_W];
        assign cur_woff = addr_q[dcache_pkg::WORD_OFF_W +: dcache_pkg::LINE_OFF_W];

        always_ff @(posedge clk) begin
                if (rst) begin
                        valid <= '0;
                        hit   <= 1'b0;
                end else begin
                        if (inv_all)
                                valid <= '0;
                        else if (fill_en)
                                valid[cur_idx] <= 1'b1;
                        if (lookup_en)
                                hit <= valid[in_idx] && (tag_mem[in_idx] == in_tag);
                end
        end

        //****************************************
        // Storage, no reset
        //****************************************
        always_ff @(posedge clk) begin
                if (lookup_en) begin
                        addr_q   <= lookup_addr;
                        hit_word <= data_mem[in_idx][in_woff*dcache_pkg::WORD_W +:
                                                     dcache_pkg::WORD_W];
                end
                if (fill_en) begin
                        tag_mem[cur_idx]  <= cur_tag;
                        data_mem[cur_idx] <= fill_line;
                end
                // Write hit patches one word of the looked-up line
                if (upd_en)
                        data_mem[cur_idx][cur_woff*dcache_pkg::WORD_W +:
                                          dcache_pkg::WORD_W] <= upd_word;
        end

        a_fill_upd_excl: assert property (@(posedge clk) disable iff (rst)
                !(fill_en && upd_en));

endmodule

//--- verilog/dcache_controller.sv
/*
 * Data cache controller
 * Blocking request FSM. Looks each request up in the array, answers
 * read hits directly, refills a line on a read miss, writes through
 * on every write, reads single beats while the cache is disabled and
 * clears all valid bits on invalidate.
 */
`timescale 1ns/1ps

module dcache_controller #(
        parameter int INDEX_W = 4
) (
        input  logic               clk,
        input  logic               rst,
        input  logic               enable,
        input  logic               invalidate_req,
        input  logic               req_valid,
        input  logic               req_write,
        input  dcache_pkg::paddr_t req_addr,
        input  dcache_pkg::word_t  req_wdata,
        input  logic               hit,
        input  dcache_pkg::word_t  hit_word,
        input  logic               fill_done,
        input  dcache_pkg::line_t  fill_line,
        output logic               invalidate_done,
        output logic               idle,
        output logic               resp_done,
        output dcache_pkg::word_t  resp_rdata,
        output logic               lookup_en,
        output dcache_pkg::paddr_t lookup_addr,
        output logic               fill_en,
        output logic               upd_en,
        output dcache_pkg::word_t  upd_word,
        output logic               inv_all,
        output logic               start,
        output logic               mem_write_cmd,
        output logic               burst_cmd,
        output dcache_pkg::paddr_t cmd_addr,
        output dcache_pkg::word_t  cmd_wdata
);

        localparam int LINE_LO = dcache_pkg::LINE_OFF_W + dcache_pkg::WORD_OFF_W;
        localparam int TAG_W   = dcache_pkg::ADDR_W - INDEX_W - LINE_LO;

        typedef enum logic [2:0] {
                S_IDLE, S_LOOKUP, S_REFILL, S_WRITE, S_UNCACHED, S_INVAL
        } state_t;

        state_t                            state;
        logic                              write_q;
        logic                              en_q;
        dcache_pkg::paddr_t                addr_q;
        dcache_pkg::word_t                 wdata_q;
        logic [dcache_pkg::LINE_OFF_W-1:0] woff;
        logic                              read_hit;

        // Invalidate takes the idle slot ahead of a request
        assign idle        = (state == S_IDLE) && !invalidate_req;
        assign lookup_en   = idle && req_valid;
        assign lookup_addr = req_addr;
        assign woff        = addr_q[dcache_pkg::WORD_OFF_W +: dcache_pkg::LINE_OFF_W];

        assign read_hit = (state == S_LOOKUP) && !write_q && en_q && hit;
        assign upd_en   = (state == S_LOOKUP) && write_q && hit;
        assign upd_word = wdata_q;
        assign fill_en  = (state == S_REFILL) && fill_done;
        assign inv_all  = (state == S_INVAL);

        //****************************************
        // Memory command, issued from lookup
        //****************************************
        assign start         = (state == S_LOOKUP) && !read_hit;
        assign mem_write_cmd = write_q;
        assign burst_cmd     = !write_q && en_q;
        assign cmd_wdata     = wdata_q;
        assign cmd_addr      = burst_cmd ?
                {addr_q[dcache_pkg::ADDR_W-1:LINE_LO], {LINE_LO{1'b0}}} :
                {addr_q[dcache_pkg::ADDR_W-1:dcache_pkg::WORD_OFF_W],
                 {dcache_pkg::WORD_OFF_W{1'b0}}};

        always_ff @(posedge clk) begin
                if (rst) begin
                        state           <= S_IDLE;
                        resp_done       <= 1'b0;
                        invalidate_done <= 1'b0;
                end else begin
                        resp_done       <= 1'b0;
                        invalidate_done <= 1'b0;
                        case (state)
                        S_IDLE: begin
                                if (invalidate_req)
                                        state <= S_INVAL;
                                else if (req_valid)
                                        state <= S_LOOKUP;
                        end
                        S_LOOKUP: begin
                                if (read_hit) begin
                                        resp_done <= 1'b1;
                                        state     <= S_IDLE;
                                end else if (write_q)
                                        state <= S_WRITE;
                                else if (en_q)
                                        state <= S_REFILL;
                                else
                                        state <= S_UNCACHED;
                        end
                        S_REFILL, S_WRITE, S_UNCACHED: begin
                                if (fill_done) begin
                                        resp_done <= 1'b1;
                                        state     <= S_IDLE;
                                end
                        end
                        S_INVAL: begin
                                invalidate_done <= 1'b1;
                                state           <= S_IDLE;
                        end
                        default: state <= S_IDLE;
                        endcase
                end
        end

        // Request capture and read data
        always_ff @(posedge clk) begin
                if (lookup_en) begin
                        write_q <= req_write;
                        en_q    <= enable;
                        addr_q  <= req_addr;
                        wdata_q <= req_wdata;
                end
                if (read_hit)
                        resp_rdata <= hit_word;
                else if (fill_done && state == S_REFILL)
                        resp_rdata <= fill_line[woff*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
                else if (fill_done)
                        resp_rdata <= fill_line[dcache_pkg::WORD_W-1:0];
        end

endmodule

//--- verilog/dcache_mem_port.sv
/*
 * Data cache memory port
 * Latches a command from the controller and drives the memory strobe
 * port. Read beats are placed into consecutive line slots, and the end
 * of each access is returned as a registered fill_done pulse.
 */
`timescale 1ns/1ps

module dcache_mem_port (
        input  logic               clk,
        input  logic               rst,
        input  logic               start,
        input  logic               mem_write_cmd,
        input  logic               burst_cmd,
        input  dcache_pkg::paddr_t cmd_addr,
        input  dcache_pkg::word_t  cmd_wdata,
        input  logic               mem_rvalid,
        input  dcache_pkg::word_t  mem_rdata,
        input  logic               mem_done,
        output logic               mem_req,
        output logic               mem_write,
        output logic               mem_burst,
        output dcache_pkg::paddr_t mem_addr,
        output dcache_pkg::word_t  mem_wdata,
        output logic               fill_done,
        output dcache_pkg::line_t  fill_line
);

        logic                              busy;
        logic [dcache_pkg::LINE_OFF_W-1:0] beat_cnt;

        always_ff @(posedge clk) begin
                if (rst) begin
                        busy      <= 1'b0;
                        mem_req   <= 1'b0;
                        fill_done <= 1'b0;
                        beat_cnt  <= '0;
                end else begin
                        mem_req   <= start;
                        fill_done <= busy && mem_done;
                        if (start)
                                busy <= 1'b1;
                        else if (mem_done)
                                busy <= 1'b0;
                        if (start)
                                beat_cnt <= '0;
                        else if (mem_rvalid)
                                beat_cnt <= beat_cnt + 1'b1;
                end
        end

        //****************************************
        // Command hold and line assembly
        //****************************************
        always_ff @(posedge clk) begin
                if (start) begin
                        mem_write <= mem_write_cmd;
                        mem_burst <= burst_cmd;
                        mem_addr  <= cmd_addr;
                        mem_wdata <= cmd_wdata;
                        fill_line <= '0;
                end else if (mem_rvalid) begin
                        fill_line[beat_cnt*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] <= mem_rdata;
                end
        end

        a_beat_while_busy: assert property (@(posedge clk) disable iff (rst)
                mem_rvalid |-> busy);

endmodule

//--- verilog/dcache_top.sv
/*
 * Data cache top level
 * Blocking direct-mapped write-through data cache with separate read
 * and write ports and one strobe memory port.
 */
`timescale 1ns/1ps

module dcache_top #(
        parameter int INDEX_W = 4
) (
        input  logic               clk,
        input  logic               rst,
        input  logic               enable,
        input  logic               invalidate_req,
        output logic               invalidate_done,
        input  logic               rd_valid,
        input  dcache_pkg::paddr_t rd_addr,
        output logic               rd_ready,
        output logic               rd_done,
        output dcache_pkg::word_t  rd_data,
        input  logic               wr_valid,
        input  dcache_pkg::paddr_t wr_addr,
        input  dcache_pkg::word_t  wr_data,
        output logic               wr_ready,
        output logic               wr_done,
        output logic               mem_req,
        output logic               mem_write,
        output logic               mem_burst,
        output dcache_pkg::paddr_t mem_addr,
        output dcache_pkg::word_t  mem_wdata,
        input  logic               mem_rvalid,
        input  dcache_pkg::word_t  mem_rdata,
        input  logic               mem_done
);

        // Internal nets share their port names, so instances connect by name
        logic               req_valid, req_write, idle, resp_done;
        dcache_pkg::paddr_t req_addr, lookup_addr, cmd_addr;
        dcache_pkg::word_t  req_wdata, resp_rdata, hit_word, upd_word, cmd_wdata;
        logic               lookup_en, hit, fill_en, upd_en, inv_all;
        logic               start, mem_write_cmd, burst_cmd, fill_done;
        dcache_pkg::line_t  fill_line;

        dcache_port_arbiter u_arbiter (.*);

        dcache_controller #(.INDEX_W(INDEX_W)) u_controller (.*);

        dcache_array #(.INDEX_W(INDEX_W)) u_array (.*);

        dcache_mem_port u_mem_port (.*);

endmodule

//--- tests/dcache_mem_model.sv
/*
 * Behavioural memory for the data cache testbench
 * Serves single reads, four-beat bursts and writes with random gaps,
 * counts requests and records the burst flag of the last one.
 */
`timescale 1ns/1ps

module dcache_mem_model (
        input  logic               clk,
        input  logic               mem_req,
        input  logic               mem_write,
        input  logic               mem_burst,
        input  dcache_pkg::paddr_t mem_addr,
        input  dcache_pkg::word_t  mem_wdata,
        output logic               mem_rvalid,
        output dcache_pkg::word_t  mem_rdata,
        output logic               mem_done,
        output int                 req_count,
        output logic               last_burst
);

        // Only written words are stored
        dcache_pkg::word_t store [dcache_pkg::paddr_t];

        // Unwritten word holds its address over the inverted address
        function automatic dcache_pkg::word_t read_word(input dcache_pkg::paddr_t a);
                if (store.exists(a))
                        return store[a];
                return {a, ~a};
        endfunction

        task automatic wait_gap();
                int gap;
                gap = $urandom % 4;
                repeat (gap) @(negedge clk);
        endtask

        initial begin
                int                 beats;
                dcache_pkg::paddr_t a;
                mem_rvalid = 1'b0;
                mem_rdata  = '0;
                mem_done   = 1'b0;
                req_count  = 0;
                last_burst = 1'b0;
                void'($urandom(35559));
                forever begin
                        @(negedge clk);
                        if (mem_req) begin
                                req_count  = req_count + 1;
                                last_burst = mem_burst;
                                a          = mem_addr;
                                if (mem_write) begin
                                        wait_gap();
                                        store[a] = mem_wdata;
                                end else begin
                                        beats = mem_burst ? 4 : 1;
                                        for (int k = 0; k < beats; k++) begin
                                                wait_gap();
                                                mem_rvalid = 1'b1;
                                                mem_rdata  = read_word(a + 8 * k);
                                                @(negedge clk);
                                                mem_rvalid = 1'b0;
                                        end
                                end
                                wait_gap();
                                mem_done = 1'b1;
                                @(negedge clk);
                                mem_done = 1'b0;
                        end
                end
        end

endmodule

//--- tests/dcache_tb.sv
/*
 * Data cache testbench
 * Replays the golden operation list against the cache and a
 * behavioural memory, checking read data, memory request counts,
 * burst use, read hit latency and port ordering.
 */
`timescale 1ns/1ps

module dcache_tb;

        localparam logic [15:0] OP_R  = {8'h00, "R"};
        localparam logic [15:0] OP_W  = {8'h00, "W"};
        localparam logic [15:0] OP_I  = {8'h00, "I"};
        localparam logic [15:0] OP_RW = "RW";
        localparam logic [15:0] OP_E0 = "E0";
        localparam logic [15:0] OP_E1 = "E1";
        localparam int CYCLES_PER_OP  = 300;

        logic               clk, rst, enable, invalidate_req, invalidate_done;
        logic               rd_valid, rd_ready, rd_done, wr_valid, wr_ready, wr_done;
        dcache_pkg::paddr_t rd_addr, wr_addr, mem_addr;
        dcache_pkg::word_t  rd_data, wr_data, mem_wdata, mem_rdata;
        logic               mem_req, mem_write, mem_burst, mem_rvalid, mem_done;
        int                 req_count;
        logic               last_burst;
        logic               loaded;

        // Golden operations
        logic [15:0]        op_q[$];
        dcache_pkg::paddr_t addr_q[$];
        dcache_pkg::word_t  wdata_q[$];
        dcache_pkg::word_t  rdata_q[$];
        int                 reqs_q[$];

        dcache_top #(.INDEX_W(4)) UUT (.*);

        dcache_mem_model u_mem (.*);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        task automatic check_word(input dcache_pkg::word_t got, input dcache_pkg::word_t exp,
                                  input string what);
                if (got !== exp) begin
                        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
                        $display("sim failed");
                        $fatal(1, "word compare failed");
                end
        endtask

        task automatic check_count(input int got, input int exp, input string what);
                if (got != exp) begin
                        $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
                        $display("sim failed");
                        $fatal(1, "count compare failed");
                end
        endtask

        task automatic load_golden();
                int                 fd;
                int                 n;
                string              line;
                logic [15:0]        op;
                dcache_pkg::paddr_t a;
                dcache_pkg::word_t  wd, rd;
                int                 rq;
                fd = $fopen("tests/dcache_golden.txt", "r");
                if (fd == 0) begin
                        $display("Cannot open tests/dcache_golden.txt for reading");
                        $display("sim failed");
                        $fatal(1, "golden file missing");
                end
                while (!$feof(fd)) begin
                        line = "";
                        n = $fgets(line, fd);
                        if (n == 0 || line.len() < 2 || line[0] == "#")
                                continue;
                        n = $sscanf(line, "%s %h %h %h %d", op, a, wd, rd, rq);
                        if (n != 5) begin
                                $display("Malformed golden line: %s", line);
                                $display("sim failed");
                                $fatal(1, "golden file format");
                        end
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        wdata_q.push_back(wd);
                        rdata_q.push_back(rd);
                        reqs_q.push_back(rq);
                end
                $fclose(fd);
        endtask

        //****************************************
        // Port sequencing, sampled at negedge
        //****************************************
        task automatic run_access(input logic do_rd, input logic do_wr,
                                  input dcache_pkg::paddr_t addr, input dcache_pkg::word_t wdata,
                                  input dcache_pkg::word_t exp_rd,
                                  output int rd_lat, output int rd_at, output int wr_at);
                int   cyc;
                int   acc_at;
                logic rd_wait, wr_wait, rd_acc, wr_acc;
                cyc     = 0;
                acc_at  = 0;
                rd_lat  = 0;
                rd_at   = 0;
                wr_at   = 0;
                rd_wait = do_rd;
                wr_wait = do_wr;
                @(negedge clk);
                rd_addr  = addr;
                wr_addr  = addr;
                wr_data  = wdata;
                rd_valid = do_rd;
                wr_valid = do_wr;
                while (rd_wait || wr_wait) begin
                        // wr_ready follows rd_valid combinationally, let it settle
                        #1;
                        // Values here are what the DUT sees at the next rising edge
                        rd_acc = rd_valid && rd_ready;
                        wr_acc = wr_valid && wr_ready;
                        if (rd_acc)
                                acc_at = cyc;
                        if (rd_done) begin
                                check_count(int'(rd_wait), 1, "rd_done without a pending read");
                                check_word(rd_data, exp_rd, "read data");
                                rd_lat  = cyc - acc_at;
                                rd_at   = cyc;
                                rd_wait = 1'b0;
                        end
                        if (wr_done) begin
                                check_count(int'(wr_wait), 1, "wr_done without a pending write");
                                wr_at   = cyc;
                                wr_wait = 1'b0;
                        end
                        @(negedge clk);
                        cyc = cyc + 1;
                        if (rd_acc)
                                rd_valid = 1'b0;
                        if (wr_acc)
                                wr_valid = 1'b0;
                end
        endtask

        task automatic run_invalidate();
                int cyc;
                @(negedge clk);
                invalidate_req = 1'b1;
                @(negedge clk);
                invalidate_req = 1'b0;
                cyc = 1;
                while (!invalidate_done) begin
                        @(negedge clk);
                        cyc = cyc + 1;
                end
                check_count(cyc, 2, "invalidate_done latency");
        endtask

        initial begin
                wait (loaded === 1'b1);
                repeat ((op_q.size() + 1) * CYCLES_PER_OP) @(posedge clk);
                $display("Timeout: golden replay did not finish in the allowed cycles");
                $display("sim failed");
                $fatal(1, "watchdog expired");
        end

        initial begin
                int   i;
                int   base;
                int   rd_lat, rd_at, wr_at;
                logic cur_en;
                rst            = 1'b1;
                enable         = 1'b0;
                invalidate_req = 1'b0;
                rd_valid       = 1'b0;
                rd_addr        = '0;
                wr_valid       = 1'b0;
                wr_addr        = '0;
                wr_data        = '0;
                loaded         = 1'b0;
                cur_en         = 1'b0;
                load_golden();
                loaded = 1'b1;
                repeat (5) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;
                @(negedge clk);
                check_count(int'(rd_ready), 1, "rd_ready after reset");
                for (i = 0; i < op_q.size(); i++) begin
                        base   = req_count;
                        rd_lat = 0;
                        rd_at  = 0;
                        wr_at  = 0;
                        if (op_q[i] == OP_E0 || op_q[i] == OP_E1) begin
                                @(negedge clk);
                                enable = (op_q[i] == OP_E1);
                                cur_en = enable;
                        end else if (op_q[i] == OP_I) begin
                                run_invalidate();
                        end else if (op_q[i] == OP_R || op_q[i] == OP_W || op_q[i] == OP_RW) begin
                                run_access(op_q[i] != OP_W, op_q[i] != OP_R, addr_q[i],
                                           wdata_q[i], rdata_q[i], rd_lat, rd_at, wr_at);
                        end else begin
                                $display("Unknown operation on golden entry %0d", i);
                                $display("sim failed");
                                $fatal(1, "bad operation");
                        end
                        check_count(req_count - base, reqs_q[i],
                                    $sformatf("memory requests for entry %0d", i));
                        if (op_q[i] == OP_R && reqs_q[i] == 0)
                                check_count(rd_lat, 2, "read hit latency");
                        if (op_q[i] == OP_R && reqs_q[i] == 1)
                                check_count(int'(last_burst), int'(cur_en), "mem_burst on read");
                        if (op_q[i] == OP_W)
                                check_count(int'(last_burst), 0, "mem_burst on write");
                        if (op_q[i] == OP_RW)
                                check_count(int'(rd_at < wr_at), 1, "rd_done ahead of wr_done");
                end
                $display("sim passed");
                $finish;
        end

endmodule

//--- tests/dcache_golden.txt
# op addr wdata expected_rdata new_mem_requests (hex, hex, hex, decimal)
# R read, W write, RW read and write together, I invalidate, E0/E1 cache enable
E1 00000000 0000000000000000 0000000000000000 0
R  00001008 0000000000000000 00001008ffffeff7 1
R  00001018 0000000000000000 00001018ffffefe7 0
W  00001010 aaaa5555aaaa5555 0000000000000000 1
R  00001010 0000000000000000 aaaa5555aaaa5555 0
W  00002020 1234567800abcdef 0000000000000000 1
R  00002020 0000000000000000 1234567800abcdef 1
R  00002028 0000000000000000 00002028ffffdfd7 0
E0 00000000 0000000000000000 0000000000000000 0
R  00001008 0000000000000000 00001008ffffeff7 1
R  00001008 0000000000000000 00001008ffffeff7 1
R  00003000 0000000000000000 00003000ffffcfff 1
E1 00000000 0000000000000000 0000000000000000 0
R  00001010 0000000000000000 aaaa5555aaaa5555 0
I  00000000 0000000000000000 0000000000000000 0
R  00001010 0000000000000000 aaaa5555aaaa5555 1
RW 00002000 5a5a5a5a0f0f0f0f 00002000ffffdfff 2
R  00002000 0000000000000000 5a5a5a5a0f0f0f0f 0
RW 00002008 0123456789abcdef 00002008ffffdff7 1
R  00002008 0000000000000000 0123456789abcdef 0

//--- list.f
verilog/dcache_pkg.sv
verilog/dcache_port_arbiter.sv
verilog/dcache_array.sv
verilog/dcache_controller.sv
verilog/dcache_mem_port.sv
verilog/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the data cache simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dcache_tb -Mdir obj_dir -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vdcache_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi
exit 0
